// File: dma_pkg.sv
// Shared constants for the TX DMA framer
// Stream count, bus widths, gate depth and the register select

package dma_pkg;

    // --------------------
    // Stream and bus sizes
    // --------------------
    localparam int NUM_STREAMS  = 4;
    localparam int STREAM_IDX_W = 2;    // Index into NUM_STREAMS
    localparam int DATA_W       = 64;   // DMA word
    localparam int FRAME_SIZE_W = 16;   // Frame sizes and packet lengths
    localparam int REG_DATA_W   = 32;

    // --------------------
    // Packet gate
    // --------------------
    localparam int GATE_DEPTH_LOG2 = 5;  // 32 words
    localparam int MAX_FRAME_WORDS = 32; // Never more than the gate holds

    // Per-stream register select
    typedef enum logic [1:0] {
        REG_CTRL       = 2'd0,  // Write only, bit 0 enable, bit 1 clear
        REG_FRAME_SIZE = 2'd1,
        REG_PKT_COUNT  = 2'd2,  // Read only
        REG_STATUS     = 2'd3   // Read only, bit 0 enable, bit 1 error
    } reg_sel_e;

endpackage

// File: dma_ctrl_regs.sv
// Per-stream control registers: enable, clear pulse, frame size
// Completed packet counters and the register read port

`timescale 1ns/1ps

module dma_ctrl_regs (
    input  logic                                               bus_clk,
    input  logic                                               i_reset,
    input  logic                                               i_reg_wr,
    input  logic                                               i_reg_rd,
    input  logic [dma_pkg::STREAM_IDX_W-1:0]                   i_reg_stream,
    input  dma_pkg::reg_sel_e                                  i_reg_sel,
    input  logic [dma_pkg::REG_DATA_W-1:0]                     i_reg_wdata,
    input  logic [dma_pkg::NUM_STREAMS-1:0]                    i_error,
    input  logic [dma_pkg::NUM_STREAMS-1:0]                    i_pkt_done,
    output logic [dma_pkg::NUM_STREAMS-1:0]                    o_enable,
    output logic [dma_pkg::NUM_STREAMS-1:0]                    o_clear,
    output logic [dma_pkg::NUM_STREAMS*dma_pkg::FRAME_SIZE_W-1:0] o_frame_size,
    output logic [dma_pkg::REG_DATA_W-1:0]                     o_reg_rdata,
    output logic                                               o_reg_rvalid
);
    import dma_pkg::*;

    logic [REG_DATA_W-1:0]   pkt_count [NUM_STREAMS];
    logic [FRAME_SIZE_W-1:0] wr_size;   // Saturated write value

    assign wr_size = (i_reg_wdata > MAX_FRAME_WORDS) ? FRAME_SIZE_W'(MAX_FRAME_WORDS)
                                                     : i_reg_wdata[FRAME_SIZE_W-1:0];

    // --------------------
    // Write side
    // --------------------
    always_ff @(posedge bus_clk) begin
        if (i_reset) begin
            o_enable <= '0;
            o_clear  <= '0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                o_frame_size[s*FRAME_SIZE_W +: FRAME_SIZE_W] <= FRAME_SIZE_W'(MAX_FRAME_WORDS);
                pkt_count[s] <= '0;
            end
        end else begin
            o_clear <= '0;  // Single cycle pulse
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (o_clear[s])
                    pkt_count[s] <= '0;
                else if (i_pkt_done[s])
                    pkt_count[s] <= pkt_count[s] + 1'b1;   // Wraps
            end
            if (i_reg_wr) begin
                case (i_reg_sel)
                    REG_CTRL: begin
                        o_enable[i_reg_stream] <= i_reg_wdata[0];
                        o_clear[i_reg_stream]  <= i_reg_wdata[1];
                    end
                    REG_FRAME_SIZE:
                        o_frame_size[i_reg_stream*FRAME_SIZE_W +: FRAME_SIZE_W] <= wr_size;
                    default: ;  // Read-only registers
                endcase
            end
        end
    end

    // --------------------
    // Read side
    // --------------------
    always_ff @(posedge bus_clk) begin
        if (i_reset) begin
            o_reg_rvalid <= 1'b0;
            o_reg_rdata  <= '0;
        end else begin
            o_reg_rvalid <= i_reg_rd;
            if (i_reg_rd) begin
                case (i_reg_sel)
                    REG_FRAME_SIZE:
                        o_reg_rdata <= REG_DATA_W'(
                            o_frame_size[i_reg_stream*FRAME_SIZE_W +: FRAME_SIZE_W]);
                    REG_PKT_COUNT: o_reg_rdata <= pkt_count[i_reg_stream];
                    REG_STATUS:
                        o_reg_rdata <= REG_DATA_W'({i_error[i_reg_stream],
                                                    o_enable[i_reg_stream]});
                    default: o_reg_rdata <= '0;  // Control is write only
                endcase
            end
        end
    end

endmodule

// File: dma_stream_framer.sv
// Lossy sample gate and frame dechunker for one DMA stream
// Cuts fixed-size frames back into packets and drops bad frames

`timescale 1ns/1ps

module dma_stream_framer (
    input  logic                             bus_clk,
    input  logic                             i_reset,
    input  logic                             i_enable,
    input  logic                             i_clear,
    input  logic [dma_pkg::FRAME_SIZE_W-1:0] i_frame_size,
    input  logic [dma_pkg::DATA_W-1:0]       i_tdata,
    input  logic                             i_tvalid,
    output logic                             o_tready,
    output logic [dma_pkg::DATA_W-1:0]       o_tdata,
    output logic                             o_tlast,
    output logic                             o_tvalid,
    input  logic                             i_tready,
    output logic                             o_error
);
    import dma_pkg::*;

    logic [FRAME_SIZE_W-1:0] word_cnt;    // Position within the frame
    logic [FRAME_SIZE_W-1:0] word_next;
    logic [FRAME_SIZE_W-1:0] pkt_len;     // Latched from the header
    logic                    drop_frame;  // Current frame is bad
    logic                    is_hdr;
    logic [FRAME_SIZE_W-1:0] hdr_len;
    logic                    hdr_bad;
    logic [FRAME_SIZE_W-1:0] cur_len;
    logic                    cur_bad;
    logic                    fwd;         // Word belongs to the packet
    logic                    beat;

    // --------------------
    // Word classification
    // --------------------
    assign is_hdr    = (word_cnt == '0);
    assign hdr_len   = i_tdata[FRAME_SIZE_W-1:0];
    assign hdr_bad   = (hdr_len == '0) || (hdr_len > i_frame_size);
    assign cur_len   = is_hdr ? hdr_len : pkt_len;
    assign cur_bad   = is_hdr ? hdr_bad : drop_frame;
    assign fwd       = !cur_bad && (word_cnt < cur_len);
    assign word_next = word_cnt + 1'b1;

    // Pass-through, padding and disabled input are swallowed
    assign o_tdata  = i_tdata;
    assign o_tlast  = (word_cnt == cur_len - 1'b1);
    assign o_tvalid = i_enable && i_tvalid && fwd;
    assign o_tready = !i_enable || !fwd || i_tready;
    assign beat     = i_enable && i_tvalid && o_tready;

    // --------------------
    // Frame state
    // --------------------
    always_ff @(posedge bus_clk) begin
        if (i_reset || i_clear) begin
            word_cnt   <= '0;
            pkt_len    <= '0;
            drop_frame <= 1'b0;
            o_error    <= 1'b0;
        end else if (!i_enable) begin
            word_cnt <= '0;   // Restart on a frame boundary when enabled
        end else if (beat) begin
            if (word_next >= i_frame_size)
                word_cnt <= '0;
            else
                word_cnt <= word_next;
            if (is_hdr) begin
                pkt_len    <= hdr_len;
                drop_frame <= hdr_bad;
                if (hdr_bad)
                    o_error <= 1'b1;   // Sticky until clear
            end
        end
    end

endmodule

// File: dma_packet_gate.sv
// Packet gate buffer for one stream
// Read side only sees packets whose last word has been written

`timescale 1ns/1ps

module dma_packet_gate (
    input  logic                       bus_clk,
    input  logic                       i_reset,
    input  logic                       i_clear,
    input  logic [dma_pkg::DATA_W-1:0] i_tdata,
    input  logic                       i_tlast,
    input  logic                       i_tvalid,
    output logic                       i_tready,
    output logic [dma_pkg::DATA_W-1:0] o_tdata,
    output logic                       o_tlast,
    output logic                       o_tvalid,
    input  logic                       o_tready,
    output logic                       o_pkt_done
);
    import dma_pkg::*;

    logic [DATA_W:0]          mem [2**GATE_DEPTH_LOG2];  // {last, data}
    logic [GATE_DEPTH_LOG2:0] wr_ptr;
    logic [GATE_DEPTH_LOG2:0] commit_ptr;   // End of last whole packet
    logic [GATE_DEPTH_LOG2:0] rd_ptr;
    logic                     full;
    logic                     wr_en;
    logic                     rd_en;

    assign full  = (wr_ptr[GATE_DEPTH_LOG2] != rd_ptr[GATE_DEPTH_LOG2]) &&
                   (wr_ptr[GATE_DEPTH_LOG2-1:0] == rd_ptr[GATE_DEPTH_LOG2-1:0]);
    assign i_tready = !full;
    assign wr_en    = i_tvalid && !full;

    assign o_tvalid   = (commit_ptr != rd_ptr);
    assign {o_tlast, o_tdata} = mem[rd_ptr[GATE_DEPTH_LOG2-1:0]];
    assign rd_en      = o_tvalid && o_tready;
    assign o_pkt_done = rd_en && o_tlast;

    always_ff @(posedge bus_clk) begin
        if (wr_en)
            mem[wr_ptr[GATE_DEPTH_LOG2-1:0]] <= {i_tlast, i_tdata};
    end

    always_ff @(posedge bus_clk) begin
        if (i_reset || i_clear) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (i_tlast)
                    commit_ptr <= wr_ptr + 1'b1;   // Publish the packet
            end
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: dma_stream_mux.sv
// Round-robin packet mux over all streams
// Grant is held until tlast, output goes through one register stage

`timescale 1ns/1ps

module dma_stream_mux (
    input  logic                                          bus_clk,
    input  logic                                          i_reset,
    input  logic [dma_pkg::NUM_STREAMS*dma_pkg::DATA_W-1:0] i_tdata,
    input  logic [dma_pkg::NUM_STREAMS-1:0]               i_tlast,
    input  logic [dma_pkg::NUM_STREAMS-1:0]               i_tvalid,
    output logic [dma_pkg::NUM_STREAMS-1:0]               o_tready,
    output logic [dma_pkg::DATA_W-1:0]                    o_m_tdata,
    output logic                                          o_m_tlast,
    output logic [dma_pkg::STREAM_IDX_W-1:0]              o_m_tdest,
    output logic                                          o_m_tvalid,
    input  logic                                          i_m_tready
);
    import dma_pkg::*;

    logic [STREAM_IDX_W-1:0] grant;     // Last stream served
    logic                    locked;    // Inside a packet
    logic [STREAM_IDX_W-1:0] pick;
    logic [STREAM_IDX_W-1:0] cand;
    logic                    found;
    logic [STREAM_IDX_W-1:0] sel;
    logic                    sel_valid;
    logic                    reg_ready;

    // --------------------
    // Arbitration
    // --------------------
    always_comb begin
        pick  = grant;
        found = 1'b0;
        cand  = grant;
        for (int k = 1; k <= NUM_STREAMS; k++) begin
            cand = STREAM_IDX_W'(grant + k);   // Next after grant first
            if (!found && i_tvalid[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign sel       = locked ? grant : pick;
    assign sel_valid = i_tvalid[sel];
    assign reg_ready = !o_m_tvalid || i_m_tready;

    always_comb begin
        o_tready = '0;
        o_tready[sel] = reg_ready;
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge bus_clk) begin
        if (i_reset) begin
            o_m_tvalid <= 1'b0;
            grant      <= STREAM_IDX_W'(NUM_STREAMS - 1);  // Stream 0 goes first
            locked     <= 1'b0;
        end else if (reg_ready) begin
            o_m_tvalid <= sel_valid;
            if (sel_valid) begin
                grant  <= sel;
                locked <= !i_tlast[sel];   // Release after tlast
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reg_ready && sel_valid) begin
            o_m_tdata <= i_tdata[sel*DATA_W +: DATA_W];
            o_m_tlast <= i_tlast[sel];
            o_m_tdest <= sel;
        end
    end

endmodule

// File: dma_tx_top.sv
// TX DMA framer top: control registers, per-stream framer and gate
// lanes, and the output packet mux

`timescale 1ns/1ps

module dma_tx_top (
    input  logic                                          bus_clk,
    input  logic                                          i_reset,
    input  logic [dma_pkg::NUM_STREAMS*dma_pkg::DATA_W-1:0] i_s_tdata,
    input  logic [dma_pkg::NUM_STREAMS-1:0]               i_s_tvalid,
    output logic [dma_pkg::NUM_STREAMS-1:0]               o_s_tready,
    output logic [dma_pkg::DATA_W-1:0]                    o_m_tdata,
    output logic                                          o_m_tlast,
    output logic [dma_pkg::STREAM_IDX_W-1:0]              o_m_tdest,
    output logic                                          o_m_tvalid,
    input  logic                                          i_m_tready,
    input  logic                                          i_reg_wr,
    input  logic                                          i_reg_rd,
    input  logic [dma_pkg::STREAM_IDX_W-1:0]              i_reg_stream,
    input  dma_pkg::reg_sel_e                             i_reg_sel,
    input  logic [dma_pkg::REG_DATA_W-1:0]                i_reg_wdata,
    output logic [dma_pkg::REG_DATA_W-1:0]                o_reg_rdata,
    output logic                                          o_reg_rvalid
);
    import dma_pkg::*;

    logic [NUM_STREAMS-1:0]              enable, clear, error, pkt_done;
    logic [NUM_STREAMS*FRAME_SIZE_W-1:0] frame_size;

    // Framer to gate, gate to mux
    logic [NUM_STREAMS*DATA_W-1:0] fr_tdata, gt_tdata;
    logic [NUM_STREAMS-1:0]        fr_tlast, fr_tvalid, fr_tready;
    logic [NUM_STREAMS-1:0]        gt_tlast, gt_tvalid, gt_tready;

    dma_ctrl_regs ctrl_regs (
        .bus_clk(bus_clk), .i_reset(i_reset),
        .i_reg_wr(i_reg_wr), .i_reg_rd(i_reg_rd), .i_reg_stream(i_reg_stream),
        .i_reg_sel(i_reg_sel), .i_reg_wdata(i_reg_wdata),
        .i_error(error), .i_pkt_done(pkt_done),
        .o_enable(enable), .o_clear(clear), .o_frame_size(frame_size),
        .o_reg_rdata(o_reg_rdata), .o_reg_rvalid(o_reg_rvalid)
    );

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_lane
        dma_stream_framer framer (
            .bus_clk(bus_clk), .i_reset(i_reset),
            .i_enable(enable[s]), .i_clear(clear[s]),
            .i_frame_size(frame_size[s*FRAME_SIZE_W +: FRAME_SIZE_W]),
            .i_tdata(i_s_tdata[s*DATA_W +: DATA_W]), .i_tvalid(i_s_tvalid[s]),
            .o_tready(o_s_tready[s]),
            .o_tdata(fr_tdata[s*DATA_W +: DATA_W]), .o_tlast(fr_tlast[s]),
            .o_tvalid(fr_tvalid[s]), .i_tready(fr_tready[s]),
            .o_error(error[s])
        );

        dma_packet_gate gate (
            .bus_clk(bus_clk), .i_reset(i_reset), .i_clear(clear[s]),
            .i_tdata(fr_tdata[s*DATA_W +: DATA_W]), .i_tlast(fr_tlast[s]),
            .i_tvalid(fr_tvalid[s]), .i_tready(fr_tready[s]),
            .o_tdata(gt_tdata[s*DATA_W +: DATA_W]), .o_tlast(gt_tlast[s]),
            .o_tvalid(gt_tvalid[s]), .o_tready(gt_tready[s]),
            .o_pkt_done(pkt_done[s])
        );
    end

    dma_stream_mux mux (
        .bus_clk(bus_clk), .i_reset(i_reset),
        .i_tdata(gt_tdata), .i_tlast(gt_tlast), .i_tvalid(gt_tvalid),
        .o_tready(gt_tready),
        .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast), .o_m_tdest(o_m_tdest),
        .o_m_tvalid(o_m_tvalid), .i_m_tready(i_m_tready)
    );

endmodule

// File: dma_tx_properties.sv
// Concurrent assertions on the TX DMA top-level output handshake and
// register read port, bound into dma_tx_top

`timescale 1ns/1ps

module dma_tx_properties (
    input logic                       bus_clk,
    input logic                       i_reset,
    input logic [dma_pkg::DATA_W-1:0] o_m_tdata,
    input logic                       o_m_tlast,
    input logic [dma_pkg::STREAM_IDX_W-1:0] o_m_tdest,
    input logic                       o_m_tvalid,
    input logic                       i_m_tready,
    input logic                       i_reg_rd,
    input logic                       o_reg_rvalid
);
    int fail_count = 0;     // Read by the testbench at the end of the run

    // Output idle right after reset
    a_idle_after_reset: assert property (@(posedge bus_clk) i_reset |=> !o_m_tvalid)
        else begin $error("o_m_tvalid high after reset"); fail_count++; end

    // Stalled output word must hold
    a_hold_when_stalled: assert property (@(posedge bus_clk) disable iff (i_reset)
        o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata) &&
                                      $stable(o_m_tlast) && $stable(o_m_tdest))
        else begin $error("o_m_* changed while stalled"); fail_count++; end

    // Read data valid exactly one cycle after the read strobe
    a_rvalid_follows_rd: assert property (@(posedge bus_clk) disable iff (i_reset)
        i_reg_rd |=> o_reg_rvalid)
        else begin $error("o_reg_rvalid missing after read"); fail_count++; end
    a_rvalid_only_after_rd: assert property (@(posedge bus_clk) disable iff (i_reset)
        !i_reg_rd |=> !o_reg_rvalid)
        else begin $error("o_reg_rvalid without a read"); fail_count++; end

endmodule

bind dma_tx_top dma_tx_properties props (
    .bus_clk(bus_clk), .i_reset(i_reset),
    .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast), .o_m_tdest(o_m_tdest),
    .o_m_tvalid(o_m_tvalid), .i_m_tready(i_m_tready),
    .i_reg_rd(i_reg_rd), .o_reg_rvalid(o_reg_rvalid)
);

// File: dma_tx_tb.sv
// TX DMA framer testbench with a stimulus table, per-stream scoreboard,
// random output back-pressure and a cycle watchdog

`timescale 1ns/1ps

module dma_tx_tb;
    import dma_pkg::*;

    localparam int NROWS = 12;

    logic                          bus_clk = 1'b0;
    logic                          i_reset;
    logic [NUM_STREAMS*DATA_W-1:0] i_s_tdata;
    logic [NUM_STREAMS-1:0]        i_s_tvalid, o_s_tready;
    logic [DATA_W-1:0]             o_m_tdata;
    logic                          o_m_tlast, o_m_tvalid, i_m_tready;
    logic [STREAM_IDX_W-1:0]       o_m_tdest;
    logic                          i_reg_wr, i_reg_rd, o_reg_rvalid;
    logic [STREAM_IDX_W-1:0]       i_reg_stream;
    reg_sel_e                      i_reg_sel;
    logic [REG_DATA_W-1:0]         i_reg_wdata, o_reg_rdata;

    // Stimulus table with one frame per row
    int row_stream [NROWS];
    int row_enable [NROWS];
    int row_fsize [NROWS];
    int row_len [NROWS];
    int row_deliver [NROWS];
    int row_error [NROWS];
    logic [DATA_W-1:0] frame_words [NROWS][0:MAX_FRAME_WORDS-1];

    // Per-stream expected words {last, data}
    logic [DATA_W:0] exp_mem [NUM_STREAMS][0:255];
    int exp_wr [NUM_STREAMS];
    int exp_rd [NUM_STREAMS];
    int rx_pkts [NUM_STREAMS];
    int err_pending [NUM_STREAMS];

    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     cycle_count = 0;
    int     cycle_limit = 1000000;

    dma_tx_top uut (.*);

    always #5 bus_clk = ~bus_clk;

    // Output back-pressure with ready on about 70% of cycles
    always @(posedge bus_clk) begin
        #1;
        i_m_tready = ({$random(seed)} % 10) >= 3;
    end

    always @(posedge bus_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        checks++;
        assert (actual === expected)
        else begin
            $display("Error at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic set_row(input int r, input int stream, input int en, input int fsize,
                           input int len, input int deliver, input int err);
        row_stream[r]  = stream;
        row_enable[r]  = en;
        row_fsize[r]   = fsize;
        row_len[r]     = len;
        row_deliver[r] = deliver;
        row_error[r]   = err;
    endtask

    // Header carries row number in 23:16 and length in 15:0
    task automatic build_frames();
        for (int r = 0; r < NROWS; r++) begin
            for (int w = 0; w < row_fsize[r]; w++) begin
                frame_words[r][w] = {$random(seed), $random(seed)};
            end
            frame_words[r][0][23:0] = {8'(r), 16'(row_len[r])};
        end
    endtask

    task automatic reg_write(input int stream, input reg_sel_e sel, input int data);
        i_reg_wr     = 1'b1;
        i_reg_stream = STREAM_IDX_W'(stream);
        i_reg_sel    = sel;
        i_reg_wdata  = REG_DATA_W'(data);
        @(posedge bus_clk);
        #1;
        i_reg_wr = 1'b0;
    endtask

    task automatic reg_read(input int stream, input reg_sel_e sel,
                            output logic [REG_DATA_W-1:0] data);
        i_reg_rd     = 1'b1;
        i_reg_stream = STREAM_IDX_W'(stream);
        i_reg_sel    = sel;
        @(posedge bus_clk);
        #1;
        i_reg_rd = 1'b0;
        check_equal("o_reg_rvalid", o_reg_rvalid, 1);
        data = o_reg_rdata;
    endtask

    task automatic queue_packet(input int r);
        int s;
        s = row_stream[r];
        for (int w = 0; w < row_len[r]; w++) begin
            exp_mem[s][exp_wr[s]] = {(w == row_len[r] - 1), frame_words[r][w]};
            exp_wr[s]++;
        end
    endtask

    task automatic send_frame(input int r);
        int   s;
        logic accepted;
        s = row_stream[r];
        for (int w = 0; w < row_fsize[r]; w++) begin
            i_s_tdata[s*DATA_W +: DATA_W] = frame_words[r][w];
            i_s_tvalid[s] = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge bus_clk);
                accepted = o_s_tready[s];
                if (!row_enable[r])
                    check_equal("o_s_tready", accepted, 1);   // Disabled never stalls
                @(posedge bus_clk);
                #1;
            end
        end
        i_s_tvalid[s] = 1'b0;
    endtask

    task automatic wait_stream_drained(input int s);
        while (exp_rd[s] != exp_wr[s]) begin
            @(posedge bus_clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        $display("Test %s: %s", name, (errors == errors_at_start) ? "ok" : "FAILED");
    endtask

    // --------------------
    // Scoreboard
    // --------------------
    always @(negedge bus_clk) begin : scoreboard
        int              d;
        logic [DATA_W:0] exp_word;
        logic            in_packet;
        int              pkt_dest;
        if (i_reset) begin
            in_packet = 1'b0;
        end else if (o_m_tvalid && i_m_tready) begin
            d = o_m_tdest;
            if (in_packet)
                check_equal("o_m_tdest", d, pkt_dest);   // No interleaving
            checks++;
            assert (exp_rd[d] != exp_wr[d])
            else begin
                $display("Word on stream %0d at time %0t, but none was expected", d, $time);
                errors++;
            end
            if (exp_rd[d] != exp_wr[d]) begin
                exp_word = exp_mem[d][exp_rd[d]];
                exp_rd[d]++;
                check_equal("o_m_tdata", o_m_tdata, exp_word[DATA_W-1:0]);
                check_equal("o_m_tlast", o_m_tlast, exp_word[DATA_W]);
                if (exp_word[DATA_W])
                    rx_pkts[d]++;   // Whole expected packet seen
            end
            in_packet = !o_m_tlast;
            pkt_dest  = d;
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int                    s;
        int                    start_errors;
        int                    total_words;
        logic [REG_DATA_W-1:0] rdata;
        logic [REG_DATA_W-1:0] count_before;

        seed         = 70;
        i_reset      = 1'b1;
        i_s_tdata    = '0;
        i_s_tvalid   = '0;
        i_m_tready   = 1'b1;
        i_reg_wr     = 1'b0;
        i_reg_rd     = 1'b0;
        i_reg_stream = '0;
        i_reg_sel    = REG_CTRL;
        i_reg_wdata  = '0;
        for (int k = 0; k < NUM_STREAMS; k++) begin
            exp_wr[k] = 0;
            exp_rd[k] = 0;
            rx_pkts[k] = 0;
            err_pending[k] = 0;
        end

        //       row stream en fsize len deliver err
        set_row(0,  0, 1, 8,  5,  1, 0);
        set_row(1,  1, 1, 16, 16, 1, 0);
        set_row(2,  2, 0, 8,  4,  0, 0);   // Disabled stream
        set_row(3,  3, 1, 4,  0,  0, 1);   // Zero length
        set_row(4,  3, 1, 4,  3,  1, 0);
        set_row(5,  0, 1, 8,  12, 0, 1);   // Longer than frame
        set_row(6,  0, 1, 32, 32, 1, 0);
        set_row(7,  2, 1, 12, 7,  1, 0);
        set_row(8,  1, 1, 24, 20, 1, 0);
        set_row(9,  2, 1, 12, 12, 1, 0);
        set_row(10, 3, 1, 32, 1,  1, 0);
        set_row(11, 1, 1, 16, 9,  1, 0);
        build_frames();

        total_words = 0;
        for (int r = 0; r < NROWS; r++)
            total_words += row_fsize[r];
        cycle_limit = 20 * total_words + 200;

        repeat (5) @(posedge bus_clk);
        #1;
        i_reset = 1'b0;

        // Frame size readback and saturation
        start_errors = errors;
        reg_write(1, REG_FRAME_SIZE, 12);
        reg_read(1, REG_FRAME_SIZE, rdata);
        check_equal("o_reg_rdata", rdata, 12);
        reg_write(1, REG_FRAME_SIZE, 40);
        reg_read(1, REG_FRAME_SIZE, rdata);
        check_equal("o_reg_rdata", rdata, MAX_FRAME_WORDS);
        report_test("register port", start_errors);

        for (int r = 0; r < NROWS; r++) begin
            s = row_stream[r];
            start_errors = errors;
            if (err_pending[s]) begin
                wait_stream_drained(s);
                reg_write(s, REG_CTRL, 2 + row_enable[r]);   // Clear with enable
                rx_pkts[s] = 0;
                err_pending[s] = 0;
            end else begin
                reg_write(s, REG_CTRL, row_enable[r]);
            end
            reg_write(s, REG_FRAME_SIZE, row_fsize[r]);
            if (!row_enable[r]) begin
                wait_stream_drained(s);
                count_before = rx_pkts[s];   // Packets delivered so far
            end
            if (row_deliver[r])
                queue_packet(r);
            send_frame(r);
            reg_read(s, REG_STATUS, rdata);
            check_equal("REG_STATUS error", rdata[1], row_error[r]);
            check_equal("REG_STATUS enable", rdata[0], row_enable[r]);
            if (!row_enable[r]) begin
                reg_read(s, REG_PKT_COUNT, rdata);
                check_equal("REG_PKT_COUNT", rdata, count_before);
            end
            if (row_error[r])
                err_pending[s] = 1;
            report_test($sformatf("row %0d on stream %0d", r, s), start_errors);
        end

        // Drain all streams before comparing counters
        start_errors = errors;
        for (int k = 0; k < NUM_STREAMS; k++)
            wait_stream_drained(k);
        for (int k = 0; k < NUM_STREAMS; k++) begin
            reg_read(k, REG_PKT_COUNT, rdata);
            check_equal("REG_PKT_COUNT", rdata, rx_pkts[k]);
        end
        check_equal("o_m_tvalid", o_m_tvalid, 0);   // Nothing left over
        report_test("packet counters", start_errors);

        errors += uut.props.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: src.f
dma_pkg.sv
dma_ctrl_regs.sv
dma_stream_framer.sv
dma_packet_gate.sv
dma_stream_mux.sv
dma_tx_top.sv
dma_tx_properties.sv
dma_tx_tb.sv
